// ==== hdl/sya_defs.svh ====
`ifndef SYA_DEFS_SVH
`define SYA_DEFS_SVH

// ======================================================================
// Array geometry
// ======================================================================

// PE rows, one activation lane each
`define SYA_ROWS 4
// PE columns, one weight lane each
`define SYA_COLS 4

// ======================================================================
// Datapath widths
// ======================================================================

`define SYA_DATA_W 8
// Product width plus headroom for long channel sums
`define SYA_ACC_W (2 * `SYA_DATA_W + 10)
`define SYA_ADDR_W 16
`define SYA_CNT_W 16

// Zero steps that push the last channel through the whole grid
`define SYA_FLUSH_STEPS (`SYA_ROWS + `SYA_COLS - 1)

`endif

// ==== hdl/sya_pkg.sv ====
`default_nettype none

`include "sya_defs.svh"

package sya_pkg;

    // Operand elements
    typedef logic signed [`SYA_DATA_W-1:0] act_t;
    typedef logic signed [`SYA_DATA_W-1:0] wgt_t;

    typedef act_t [`SYA_ROWS-1:0] act_vec_t;
    typedef wgt_t [`SYA_COLS-1:0] wgt_vec_t;

    // Accumulators, indexed [row][col]
    typedef logic signed [`SYA_ACC_W-1:0] acc_t;
    typedef acc_t [`SYA_ROWS-1:0][`SYA_COLS-1:0] acc_grid_t;

    // Requantized output
    typedef logic [`SYA_DATA_W-1:0] ofm_t;
    typedef ofm_t [`SYA_COLS-1:0] ofm_row_t;

    typedef logic [`SYA_ADDR_W-1:0] addr_t;
    typedef logic [`SYA_CNT_W-1:0] cnt_t;

    // Config word, tile and channel counts are never zero
    typedef struct packed {
        addr_t                  ofm_base;
        addr_t                  act_base;
        addr_t                  wgt_base;
        cnt_t                   num_til_ifm;
        cnt_t                   num_til_flt;
        cnt_t                   num_chn;
        logic [`SYA_DATA_W-1:0] shift;
        ofm_t                   zp;
        logic                   loop_order;
    } sya_cfg_t;

endpackage

`default_nettype wire

// ==== hdl/sya_feed_if.sv ====
`default_nettype none

interface sya_feed_if
    import sya_pkg::*;
();

    // One shift-and-accumulate cycle of the whole grid
    logic     step;
    // Unskewed operand vectors, zero while flushing
    act_vec_t act_vec;
    wgt_vec_t wgt_vec;
    // Tile end, takes the sums and clears the grid
    logic     capture;

    modport seq (output step, output act_vec, output wgt_vec, output capture);

    modport skew (input step, input act_vec, input wgt_vec);

    modport array (input step, input capture);

endinterface

`default_nettype wire

// ==== hdl/sya_loop_seq.sv ====
`default_nettype none

`include "sya_defs.svh"

module sya_loop_seq
    import sya_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cfg_vld,
    output logic     cfg_rdy,
    input  sya_cfg_t cfg_info,
    output logic     act_rd_addr_vld,
    input  logic     act_rd_addr_rdy,
    output addr_t    act_rd_addr,
    output logic     wgt_rd_addr_vld,
    input  logic     wgt_rd_addr_rdy,
    output addr_t    wgt_rd_addr,
    input  logic     act_rd_dat_vld,
    input  act_vec_t act_rd_dat,
    input  logic     wgt_rd_dat_vld,
    input  wgt_vec_t wgt_rd_dat,
    output logic     rd_dat_rdy,
    sya_feed_if.seq  feed,
    input  logic     drain_free,
    output sya_cfg_t cfg,
    output addr_t    tile_ofm_addr
);

    localparam int FLUSH_W = $clog2(`SYA_FLUSH_STEPS + 1);

    typedef enum logic [1:0] {S_IDLE, S_FEED, S_FLUSH, S_CAPT} seq_state_t;

    // Position in the loop nest
    typedef struct packed {
        cnt_t ifm;
        cnt_t flt;
        cnt_t chn;
    } loop_pos_t;

    seq_state_t         state;
    sya_cfg_t           cfg_q;
    loop_pos_t          a_pos;
    loop_pos_t          d_pos;
    logic               addr_done;
    logic [FLUSH_W-1:0] flush_cnt;
    logic               cfg_hs;
    logic               addr_vld;
    logic               addr_hs;
    logic               dat_hs;
    logic               flush_step;

    function automatic logic pos_last(loop_pos_t p, sya_cfg_t c);
        return (p.chn == c.num_chn - 1'b1) &&
               (p.ifm == c.num_til_ifm - 1'b1) &&
               (p.flt == c.num_til_flt - 1'b1);
    endfunction

    // Channel innermost, then the tile loop picked by loop_order
    function automatic loop_pos_t next_pos(loop_pos_t p, sya_cfg_t c);
        loop_pos_t n;
        logic      ifm_end;
        logic      flt_end;
        n       = p;
        ifm_end = (p.ifm == c.num_til_ifm - 1'b1);
        flt_end = (p.flt == c.num_til_flt - 1'b1);
        if (p.chn != c.num_chn - 1'b1) begin
            n.chn = p.chn + 1'b1;
        end else begin
            n.chn = '0;
            if (!c.loop_order) begin
                n.flt = flt_end ? '0 : p.flt + 1'b1;
                if (flt_end) begin
                    n.ifm = ifm_end ? '0 : p.ifm + 1'b1;
                end
            end else begin
                n.ifm = ifm_end ? '0 : p.ifm + 1'b1;
                if (ifm_end) begin
                    n.flt = flt_end ? '0 : p.flt + 1'b1;
                end
            end
        end
        return n;
    endfunction

    assign cfg_rdy = (state == S_IDLE);
    assign cfg_hs  = cfg_vld & cfg_rdy;
    assign cfg     = cfg_q;

    always_ff @(posedge clk) begin
        if (cfg_hs) begin
            cfg_q <= cfg_info;
        end
    end

    // ==================================================================
    // Read address issue
    // ==================================================================

    // Both channels transfer in the same cycle
    assign addr_vld        = (state != S_IDLE) & ~addr_done;
    assign act_rd_addr_vld = addr_vld & wgt_rd_addr_rdy;
    assign wgt_rd_addr_vld = addr_vld & act_rd_addr_rdy;
    assign addr_hs         = addr_vld & act_rd_addr_rdy & wgt_rd_addr_rdy;

    assign act_rd_addr = cfg_q.act_base + a_pos.ifm * cfg_q.num_chn + a_pos.chn;
    assign wgt_rd_addr = cfg_q.wgt_base + a_pos.flt * cfg_q.num_chn + a_pos.chn;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_pos     <= '0;
            addr_done <= 1'b0;
        end else if (cfg_hs) begin
            a_pos     <= '0;
            addr_done <= 1'b0;
        end else if (addr_hs) begin
            a_pos     <= next_pos(a_pos, cfg_q);
            addr_done <= pos_last(a_pos, cfg_q);
        end
    end

    // ==================================================================
    // Data acceptance, flush and capture
    // ==================================================================

    assign rd_dat_rdy = (state == S_FEED);
    assign dat_hs     = rd_dat_rdy & act_rd_dat_vld & wgt_rd_dat_vld;
    // Held while the previous tile still drains
    assign flush_step = (state == S_FLUSH) & drain_free;

    assign feed.step    = dat_hs | flush_step;
    assign feed.act_vec = (state == S_FEED) ? act_rd_dat : '0;
    assign feed.wgt_vec = (state == S_FEED) ? wgt_rd_dat : '0;
    assign feed.capture = (state == S_CAPT);

    // d_pos still names the tile being captured
    assign tile_ofm_addr = cfg_q.ofm_base +
        (d_pos.ifm * cfg_q.num_til_flt + d_pos.flt) * addr_t'(`SYA_ROWS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            d_pos     <= '0;
            flush_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cfg_hs) begin
                        state <= S_FEED;
                        d_pos <= '0;
                    end
                end
                S_FEED: begin
                    if (dat_hs) begin
                        if (d_pos.chn == cfg_q.num_chn - 1'b1) begin
                            state     <= S_FLUSH;
                            flush_cnt <= '0;
                        end else begin
                            d_pos.chn <= d_pos.chn + 1'b1;
                        end
                    end
                end
                S_FLUSH: begin
                    if (flush_step) begin
                        if (flush_cnt == FLUSH_W'(`SYA_FLUSH_STEPS - 1)) begin
                            state <= S_CAPT;
                        end else begin
                            flush_cnt <= flush_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    // Capture cycle, move on to the next tile or stop
                    d_pos <= next_pos(d_pos, cfg_q);
                    state <= pos_last(d_pos, cfg_q) ? S_IDLE : S_FEED;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sya_operand_skew.sv ====
`default_nettype none

module sya_operand_skew #(
    parameter type lane_t  = logic [7:0],
    parameter int  LANES   = 4,
    // Selects the weight vector of the feed instead of the activations
    parameter bit  USE_WGT = 1'b0
) (
    input  logic              clk,
    input  logic              rst_n,
    sya_feed_if.skew          feed,
    output lane_t [LANES-1:0] vec_out
);

    for (genvar n = 0; n < LANES; n++) begin : g_lane
        lane_t lane_in;

        if (USE_WGT) begin : g_wgt
            assign lane_in = lane_t'(feed.wgt_vec[n]);
        end else begin : g_act
            assign lane_in = lane_t'(feed.act_vec[n]);
        end

        if (n == 0) begin : g_pass
            assign vec_out[n] = lane_in;
        end else begin : g_dly
            // n stages, advanced only on step
            lane_t taps [n];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int j = 0; j < n; j++) begin
                        taps[j] <= '0;
                    end
                end else if (feed.step) begin
                    taps[0] <= lane_in;
                    for (int j = 1; j < n; j++) begin
                        taps[j] <= taps[j-1];
                    end
                end
            end

            assign vec_out[n] = taps[n-1];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sya_pe_array.sv ====
`default_nettype none

`include "sya_defs.svh"

module sya_pe_array
    import sya_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    sya_feed_if.array  feed,
    input  act_vec_t   act_skewed,
    input  wgt_vec_t   wgt_skewed,
    output acc_grid_t  acc_grid
);

    // Operand registers, activations move east and weights south
    act_t a_q [`SYA_ROWS][`SYA_COLS];
    wgt_t w_q [`SYA_ROWS][`SYA_COLS];

    for (genvar r = 0; r < `SYA_ROWS; r++) begin : g_row
        for (genvar c = 0; c < `SYA_COLS; c++) begin : g_col
            act_t a_in;
            wgt_t w_in;
            acc_t acc_q;

            // West edge takes the skewed lane, inner cells the west neighbour
            if (c == 0) begin : g_west
                assign a_in = act_skewed[r];
            end else begin : g_inner_a
                assign a_in = a_q[r][c-1];
            end

            // North edge takes the skewed lane
            if (r == 0) begin : g_north
                assign w_in = wgt_skewed[c];
            end else begin : g_inner_w
                assign w_in = w_q[r-1][c];
            end

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    a_q[r][c] <= '0;
                    w_q[r][c] <= '0;
                    acc_q     <= '0;
                end else if (feed.capture) begin
                    acc_q <= '0;
                end else if (feed.step) begin
                    a_q[r][c] <= a_in;
                    w_q[r][c] <= w_in;
                    acc_q     <= acc_q + acc_t'(a_in) * acc_t'(w_in);
                end
            end

            assign acc_grid[r][c] = acc_q;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sya_ofm_drain.sv ====
`default_nettype none

`include "sya_defs.svh"

module sya_ofm_drain
    import sya_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      capture,
    input  acc_grid_t acc_grid,
    input  addr_t     tile_ofm_addr,
    input  sya_cfg_t  cfg,
    output logic      drain_free,
    output logic      ofm_wr_vld,
    input  logic      ofm_wr_rdy,
    output addr_t     ofm_wr_addr,
    output ofm_row_t  ofm_wr_dat
);

    localparam int ROW_W = $clog2(`SYA_ROWS);

    acc_grid_t              grid_q;
    addr_t                  base_q;
    logic [`SYA_DATA_W-1:0] shift_q;
    ofm_t                   zp_q;
    logic                   busy;
    logic [ROW_W-1:0]       row_q;

    // ReLU, then an 8-bit slice plus zero point, wrapping
    function automatic ofm_t requant(acc_t v, logic [`SYA_DATA_W-1:0] sh, ofm_t zp);
        if (v < 0) begin
            return '0;
        end
        return ofm_t'(v >>> sh) + zp;
    endfunction

    // Copy of the tile, frees the grid for the next one
    always_ff @(posedge clk) begin
        if (capture) begin
            grid_q  <= acc_grid;
            base_q  <= tile_ofm_addr;
            shift_q <= cfg.shift;
            zp_q    <= cfg.zp;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            row_q <= '0;
        end else if (capture) begin
            busy  <= 1'b1;
            row_q <= '0;
        end else if (busy && ofm_wr_rdy) begin
            if (row_q == ROW_W'(`SYA_ROWS - 1)) begin
                busy <= 1'b0;
            end
            row_q <= row_q + 1'b1;
        end
    end

    assign drain_free  = ~busy;
    assign ofm_wr_vld  = busy;
    assign ofm_wr_addr = base_q + addr_t'(row_q);

    always_comb begin
        for (int c = 0; c < `SYA_COLS; c++) begin
            ofm_wr_dat[c] = requant(grid_q[row_q][c], shift_q, zp_q);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sya_top.sv ====
`default_nettype none

`include "sya_defs.svh"

module sya_top
    import sya_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cfg_vld,
    output logic     cfg_rdy,
    input  sya_cfg_t cfg_info,
    output logic     act_rd_addr_vld,
    input  logic     act_rd_addr_rdy,
    output addr_t    act_rd_addr,
    output logic     wgt_rd_addr_vld,
    input  logic     wgt_rd_addr_rdy,
    output addr_t    wgt_rd_addr,
    input  logic     act_rd_dat_vld,
    input  act_vec_t act_rd_dat,
    input  logic     wgt_rd_dat_vld,
    input  wgt_vec_t wgt_rd_dat,
    output logic     rd_dat_rdy,
    output logic     ofm_wr_vld,
    input  logic     ofm_wr_rdy,
    output addr_t    ofm_wr_addr,
    output ofm_row_t ofm_wr_dat
);

    act_vec_t  act_skewed;
    wgt_vec_t  wgt_skewed;
    acc_grid_t acc_grid;
    sya_cfg_t  cfg;
    addr_t     tile_ofm_addr;
    logic      drain_free;

    sya_feed_if feed ();

    // ==================================================================
    // Loop control and operand feed
    // ==================================================================

    sya_loop_seq u_loop_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_vld         (cfg_vld),
        .cfg_rdy         (cfg_rdy),
        .cfg_info        (cfg_info),
        .act_rd_addr_vld (act_rd_addr_vld),
        .act_rd_addr_rdy (act_rd_addr_rdy),
        .act_rd_addr     (act_rd_addr),
        .wgt_rd_addr_vld (wgt_rd_addr_vld),
        .wgt_rd_addr_rdy (wgt_rd_addr_rdy),
        .wgt_rd_addr     (wgt_rd_addr),
        .act_rd_dat_vld  (act_rd_dat_vld),
        .act_rd_dat      (act_rd_dat),
        .wgt_rd_dat_vld  (wgt_rd_dat_vld),
        .wgt_rd_dat      (wgt_rd_dat),
        .rd_dat_rdy      (rd_dat_rdy),
        .feed            (feed),
        .drain_free      (drain_free),
        .cfg             (cfg),
        .tile_ofm_addr   (tile_ofm_addr)
    );

    // West edge, one lane per row
    sya_operand_skew #(
        .lane_t  (act_t),
        .LANES   (`SYA_ROWS),
        .USE_WGT (1'b0)
    ) u_act_skew (
        .clk     (clk),
        .rst_n   (rst_n),
        .feed    (feed),
        .vec_out (act_skewed)
    );

    // North edge, one lane per column
    sya_operand_skew #(
        .lane_t  (wgt_t),
        .LANES   (`SYA_COLS),
        .USE_WGT (1'b1)
    ) u_wgt_skew (
        .clk     (clk),
        .rst_n   (rst_n),
        .feed    (feed),
        .vec_out (wgt_skewed)
    );

    // ==================================================================
    // Compute and result drain
    // ==================================================================

    sya_pe_array u_pe_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .feed       (feed),
        .act_skewed (act_skewed),
        .wgt_skewed (wgt_skewed),
        .acc_grid   (acc_grid)
    );

    sya_ofm_drain u_ofm_drain (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture       (feed.capture),
        .acc_grid      (acc_grid),
        .tile_ofm_addr (tile_ofm_addr),
        .cfg           (cfg),
        .drain_free    (drain_free),
        .ofm_wr_vld    (ofm_wr_vld),
        .ofm_wr_rdy    (ofm_wr_rdy),
        .ofm_wr_addr   (ofm_wr_addr),
        .ofm_wr_dat    (ofm_wr_dat)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_sya.sv ====
`default_nettype none

`include "sya_defs.svh"

module tb_sya
    import sya_pkg::*;
();

    localparam logic [31:0] LFSR_POLY = 32'h80200003;

    logic     clk;
    logic     rst_n;
    logic     cfg_vld;
    logic     cfg_rdy;
    sya_cfg_t cfg_info;
    logic     act_rd_addr_vld;
    logic     act_rd_addr_rdy;
    addr_t    act_rd_addr;
    logic     wgt_rd_addr_vld;
    logic     wgt_rd_addr_rdy;
    addr_t    wgt_rd_addr;
    logic     act_rd_dat_vld;
    act_vec_t act_rd_dat;
    logic     wgt_rd_dat_vld;
    wgt_vec_t wgt_rd_dat;
    logic     rd_dat_rdy;
    logic     ofm_wr_vld;
    logic     ofm_wr_rdy;
    addr_t    ofm_wr_addr;
    ofm_row_t ofm_wr_dat;

    // Operand memories and the model's expectations
    act_vec_t act_mem [256];
    wgt_vec_t wgt_mem [256];
    addr_t    exp_act_q [$];
    addr_t    exp_wgt_q [$];
    addr_t    exp_ofm_addr_q [$];
    ofm_row_t exp_ofm_row_q [$];
    // Accepted reads waiting to be returned in order
    addr_t    rd_act_q [$];
    addr_t    rd_wgt_q [$];
    int       rd_due_q [$];

    logic [31:0] lfsr;
    logic        stall_en;
    logic        ofm_held;
    addr_t       held_addr;
    ofm_row_t    held_row;
    int          cyc;
    int          errors;
    int          pass_cnt;
    int          fail_cnt;
    int          neg_cnt;
    int          wrap_cnt;
    int          stall_seen;

    sya_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_vld         (cfg_vld),
        .cfg_rdy         (cfg_rdy),
        .cfg_info        (cfg_info),
        .act_rd_addr_vld (act_rd_addr_vld),
        .act_rd_addr_rdy (act_rd_addr_rdy),
        .act_rd_addr     (act_rd_addr),
        .wgt_rd_addr_vld (wgt_rd_addr_vld),
        .wgt_rd_addr_rdy (wgt_rd_addr_rdy),
        .wgt_rd_addr     (wgt_rd_addr),
        .act_rd_dat_vld  (act_rd_dat_vld),
        .act_rd_dat      (act_rd_dat),
        .wgt_rd_dat_vld  (wgt_rd_dat_vld),
        .wgt_rd_dat      (wgt_rd_dat),
        .rd_dat_rdy      (rd_dat_rdy),
        .ofm_wr_vld      (ofm_wr_vld),
        .ofm_wr_rdy      (ofm_wr_rdy),
        .ofm_wr_addr     (ofm_wr_addr),
        .ofm_wr_dat      (ofm_wr_dat)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ======================================================================
    // Random source and reference model
    // ======================================================================

    // Galois LFSR stepped once per bit
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ LFSR_POLY;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Negative sums clip to zero, else an 8-bit slice plus zero point mod 256
    function automatic ofm_t requantize(input longint s, input int sh, input int zp);
        longint slice;
        if (s < 0) begin
            return '0;
        end
        slice = (s >> sh) & 255;
        return ofm_t'(slice + zp);
    endfunction

    function automatic sya_cfg_t make_cfg(input int n_ifm, input int n_flt, input int n_chn,
                                          input logic order, input int sh, input int zp,
                                          input int ofm_b, input int act_b, input int wgt_b);
        sya_cfg_t c;
        c             = '0;
        c.ofm_base    = addr_t'(ofm_b);
        c.act_base    = addr_t'(act_b);
        c.wgt_base    = addr_t'(wgt_b);
        c.num_til_ifm = cnt_t'(n_ifm);
        c.num_til_flt = cnt_t'(n_flt);
        c.num_chn     = cnt_t'(n_chn);
        c.shift       = 8'(sh);
        c.zp          = ofm_t'(zp);
        c.loop_order  = order;
        return c;
    endfunction

    // Generous cycle budget for one run
    function automatic int run_cycles(input int n_ifm, input int n_flt, input int n_chn,
                                      input logic stall);
        int per_tile;
        per_tile = n_chn + `SYA_FLUSH_STEPS + `SYA_ROWS + 4;
        return n_ifm * n_flt * per_tile * (stall ? 8 : 1) + 40;
    endfunction

    task automatic build_expect(input sya_cfg_t c);
        int       n_out;
        int       n_in;
        int       i;
        int       f;
        int       ai;
        int       wi;
        longint   s;
        ofm_row_t row;
        n_out    = c.loop_order ? int'(c.num_til_flt) : int'(c.num_til_ifm);
        n_in     = c.loop_order ? int'(c.num_til_ifm) : int'(c.num_til_flt);
        neg_cnt  = 0;
        wrap_cnt = 0;
        for (int o = 0; o < n_out; o++) begin
            for (int n = 0; n < n_in; n++) begin
                i = c.loop_order ? n : o;
                f = c.loop_order ? o : n;
                for (int k = 0; k < int'(c.num_chn); k++) begin
                    exp_act_q.push_back(addr_t'(c.act_base + i * c.num_chn + k));
                    exp_wgt_q.push_back(addr_t'(c.wgt_base + f * c.num_chn + k));
                end
                for (int r = 0; r < `SYA_ROWS; r++) begin
                    for (int col = 0; col < `SYA_COLS; col++) begin
                        s = 0;
                        for (int k = 0; k < int'(c.num_chn); k++) begin
                            ai = int'(c.act_base) + i * int'(c.num_chn) + k;
                            wi = int'(c.wgt_base) + f * int'(c.num_chn) + k;
                            s += longint'($signed(act_mem[ai][r])) *
                                 longint'($signed(wgt_mem[wi][col]));
                        end
                        if (s < 0) begin
                            neg_cnt++;
                        end else if (((s >> c.shift) & 255) + c.zp > 255) begin
                            wrap_cnt++;
                        end
                        row[col] = requantize(s, int'(c.shift), int'(c.zp));
                    end
                    exp_ofm_addr_q.push_back(
                        addr_t'(c.ofm_base + (i * c.num_til_flt + f) * `SYA_ROWS + r));
                    exp_ofm_row_q.push_back(row);
                end
            end
        end
    endtask

    // ======================================================================
    // Checks
    // ======================================================================

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc);
            errors++;
        end
    endtask

    task automatic check_row(input string name, input ofm_row_t got, input ofm_row_t exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc);
            errors++;
        end
    endtask

    task automatic check_ctrl(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("%s: PASS", name);
            pass_cnt++;
        end else begin
            $display("%s: FAIL with %0d errors", name, errors - err_before);
            fail_cnt++;
        end
    endtask

    // ======================================================================
    // Buffer and ofm bus model
    // ======================================================================

    // Sample on the rising edge, drive on the falling edge
    initial begin : bus_model
        int   lat;
        int   idx;
        logic act_hs;
        logic wgt_hs;
        logic nxt_act_rdy;
        logic nxt_wgt_rdy;
        logic nxt_ofm_rdy;
        act_rd_addr_rdy = 1'b0;
        wgt_rd_addr_rdy = 1'b0;
        act_rd_dat_vld  = 1'b0;
        wgt_rd_dat_vld  = 1'b0;
        act_rd_dat      = '0;
        wgt_rd_dat      = '0;
        ofm_wr_rdy      = 1'b0;
        ofm_held        = 1'b0;
        forever begin
            @(posedge clk);
            cyc++;
            act_hs = act_rd_addr_vld && act_rd_addr_rdy;
            wgt_hs = wgt_rd_addr_vld && wgt_rd_addr_rdy;
            check_ctrl("wgt_rd_addr handshake", wgt_hs, act_hs);
            if (act_hs) begin
                if (exp_act_q.size() == 0) begin
                    $display("Read address 0x%h issued past the end of the run", act_rd_addr);
                    errors++;
                end else begin
                    check_addr("act_rd_addr", act_rd_addr, exp_act_q.pop_front());
                    check_addr("wgt_rd_addr", wgt_rd_addr, exp_wgt_q.pop_front());
                end
                lat = stall_en ? int'(rand_bits(2)) : 0;
                rd_act_q.push_back(act_rd_addr);
                rd_wgt_q.push_back(wgt_rd_addr);
                rd_due_q.push_back(cyc + lat);
            end
            if (act_rd_dat_vld && rd_dat_rdy) begin
                void'(rd_act_q.pop_front());
                void'(rd_wgt_q.pop_front());
                void'(rd_due_q.pop_front());
            end
            // A stalled row must hold still
            if (ofm_held && !ofm_wr_vld) begin
                $display("Row at 0x%h withdrawn before it was accepted, cycle %0d",
                         held_addr, cyc);
                errors++;
            end
            if (ofm_held && ofm_wr_vld) begin
                stall_seen++;
                check_addr("ofm_wr_addr", ofm_wr_addr, held_addr);
                check_row("ofm_wr_dat", ofm_wr_dat, held_row);
            end
            if (ofm_wr_vld && ofm_wr_rdy) begin
                if (exp_ofm_addr_q.size() == 0) begin
                    $display("Unexpected ofm row written to 0x%h at cycle %0d", ofm_wr_addr, cyc);
                    errors++;
                end else begin
                    check_addr("ofm_wr_addr", ofm_wr_addr, exp_ofm_addr_q.pop_front());
                    check_row("ofm_wr_dat", ofm_wr_dat, exp_ofm_row_q.pop_front());
                end
            end
            ofm_held    = ofm_wr_vld && !ofm_wr_rdy;
            held_addr   = ofm_wr_addr;
            held_row    = ofm_wr_dat;
            nxt_act_rdy = stall_en ? (rand_bits(2) != 0) : 1'b1;
            nxt_wgt_rdy = stall_en ? (rand_bits(2) != 0) : 1'b1;
            nxt_ofm_rdy = stall_en ? (rand_bits(2) != 0) : 1'b1;

            @(negedge clk);
            act_rd_addr_rdy = nxt_act_rdy;
            wgt_rd_addr_rdy = nxt_wgt_rdy;
            ofm_wr_rdy      = nxt_ofm_rdy;
            if (rd_due_q.size() != 0 && rd_due_q[0] <= cyc) begin
                idx            = int'(rd_act_q[0][7:0]);
                act_rd_dat     = act_mem[idx];
                idx            = int'(rd_wgt_q[0][7:0]);
                wgt_rd_dat     = wgt_mem[idx];
                act_rd_dat_vld = 1'b1;
                wgt_rd_dat_vld = 1'b1;
            end else begin
                act_rd_dat     = '0;
                wgt_rd_dat     = '0;
                act_rd_dat_vld = 1'b0;
                wgt_rd_dat_vld = 1'b0;
            end
        end
    end

    // ======================================================================
    // Tests
    // ======================================================================

    task automatic run_cfg(input sya_cfg_t c, input logic stall);
        stall_en = stall;
        build_expect(c);
        @(negedge clk);
        cfg_info = c;
        cfg_vld  = 1'b1;
        @(posedge clk);
        while (!cfg_rdy) begin
            @(posedge clk);
        end
        @(negedge clk);
        cfg_vld = 1'b0;
        check_ctrl("cfg_rdy", cfg_rdy, 1'b0);
        while (exp_ofm_addr_q.size() != 0) begin
            @(negedge clk);
        end
        check_ctrl("cfg_rdy", cfg_rdy, 1'b1);
        check_ctrl("ofm_wr_vld", ofm_wr_vld, 1'b0);
        if (exp_act_q.size() != 0 || rd_act_q.size() != 0) begin
            $display("Run ended with %0d addresses never issued and %0d reads never taken",
                     exp_act_q.size(), rd_act_q.size());
            errors++;
        end
    endtask

    initial begin : watchdog
        int limit;
        limit = 50 + 3 * run_cycles(2, 2, 4, 1'b0) + run_cycles(3, 2, 5, 1'b1) +
                run_cycles(1, 1, 1, 1'b0) + run_cycles(2, 3, 3, 1'b0);
        repeat (limit) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main
        int e0;
        rst_n      = 1'b0;
        cfg_vld    = 1'b0;
        cfg_info   = '0;
        stall_en   = 1'b0;
        cyc        = 0;
        errors     = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        stall_seen = 0;
        lfsr       = 32'h832a0436;
        for (int a = 0; a < 256; a++) begin
            for (int l = 0; l < `SYA_ROWS; l++) begin
                act_mem[a][l] = act_t'(rand_bits(8));
            end
            for (int l = 0; l < `SYA_COLS; l++) begin
                wgt_mem[a][l] = wgt_t'(rand_bits(8));
            end
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        e0 = errors;
        check_ctrl("cfg_rdy", cfg_rdy, 1'b1);
        check_ctrl("act_rd_addr_vld", act_rd_addr_vld, 1'b0);
        check_ctrl("wgt_rd_addr_vld", wgt_rd_addr_vld, 1'b0);
        check_ctrl("rd_dat_rdy", rd_dat_rdy, 1'b0);
        check_ctrl("ofm_wr_vld", ofm_wr_vld, 1'b0);
        report_test("test 1 reset state", e0);

        e0 = errors;
        run_cfg(make_cfg(2, 2, 4, 1'b0, 0, 0, 'h100, 0, 16), 1'b0);
        report_test("test 2 loop order 0", e0);

        e0 = errors;
        run_cfg(make_cfg(2, 2, 4, 1'b1, 0, 0, 'h100, 0, 16), 1'b0);
        report_test("test 3 loop order 1", e0);

        e0 = errors;
        run_cfg(make_cfg(2, 2, 4, 1'b0, 5, 'hc8, 'h200, 32, 48), 1'b0);
        if (neg_cnt == 0 || wrap_cnt == 0) begin
            $display("Requantization edges not reached, %0d negative and %0d wrapping sums",
                     neg_cnt, wrap_cnt);
            errors++;
        end
        report_test("test 4 requantization edges", e0);

        e0         = errors;
        stall_seen = 0;
        run_cfg(make_cfg(3, 2, 5, 1'b1, 3, 'h11, 'h300, 64, 96), 1'b1);
        if (stall_seen == 0) begin
            $display("No ofm row was ever stalled, hold behaviour went unchecked");
            errors++;
        end
        report_test("test 5 random stalls", e0);

        e0 = errors;
        run_cfg(make_cfg(1, 1, 1, 1'b0, 2, 7, 'h400, 128, 160), 1'b0);
        run_cfg(make_cfg(2, 3, 3, 1'b1, 2, 7, 'h500, 136, 176), 1'b0);
        report_test("test 6 back to back configs", e0);

        $display("%0d tests passed, %0d tests failed, %0d errors", pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hdl
hdl/sya_pkg.sv
hdl/sya_feed_if.sv
hdl/sya_loop_seq.sv
hdl/sya_operand_skew.sv
hdl/sya_pe_array.sv
hdl/sya_ofm_drain.sv
hdl/sya_top.sv
testbench/tb_sya.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_sya -f tb.f -o tb_sya_sim \
    && ./obj_dir/tb_sya_sim > sim.log 2>&1 \
    || echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log \
    && echo "Simulation result: pass" \
    || { echo "Simulation result: fail"; exit 1; }
